//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SPI SRAM testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_spirw_sram \
    -f spirw_sram.f \
    -o Vtb_spirw_sram

./obj_dir/Vtb_spirw_sram 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- spirw_sram.f
verilog/spi_pkg.sv
verilog/mem_pkg.sv
verilog/sram_bank.sv
verilog/bank_select.sv
verilog/bank_read_mux.sv
verilog/spirw_slave.sv
verilog/spirw_sram_top.sv
tb/tb_spirw_sram.sv

//--- tb/tb_spirw_sram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spirw_sram import spi_pkg::*, mem_pkg::*;;

    localparam int MEM_BYTES   = BANK_COUNT * (2 ** ROW_BITS);
    localparam int ADDR_BITS   = ROW_BITS + BANK_BITS;
    localparam int HALF_CYCLES = 6;     // clk cycles per sclk phase
    localparam int CLK_NS      = 8;

    // byte i of the payload sits at data[8*i +: 8]
    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] addr;
        logic [3:0]  count;
        logic [2:0]  cut_bits;          // bits of one extra byte before csn rises
        logic        exp_from_entry;    // read bytes expected from data instead of model
        logic [71:0] data;
    } txn_t;

    logic       clk;
    logic       rst_n;
    logic       csn;
    logic       sclk;
    logic       mosi;
    wire        miso;

    txn_t       txns [$];
    string      names [$];
    logic [7:0] model [MEM_BYTES];      // reference memory with 1 KiB aliasing
    bit         table_ready;

    spirw_sram_top i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .csn(csn),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic fail_now(input string reason);
        $display("Test failures found");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            fail_now("read data mismatch");
        end
    endtask

    task automatic check_idle(input string name, input spi_state_t phase);
        if (miso !== 1'b0) begin
            $display("error: %s miso in %s expected 0 actual %b", name, phase.name(), miso);
            fail_now("miso driven while it should be idle");
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // mode 0 byte with miso sampled just before sclk rises
    task automatic spi_byte(input string name, input logic [7:0] tx, input int nbits,
                            input bit idle_chk, output logic [7:0] rx);
        rx = '0;
        for (int b = 7; b > 7 - nbits; b--) begin
            mosi = tx[b];
            wait_cycles(HALF_CYCLES);
            if (idle_chk) begin
                check_idle(name, ST_IGNORE);
            end
            rx   = {rx[6:0], miso};
            sclk = 1'b1;
            wait_cycles(HALF_CYCLES);
            sclk = 1'b0;
        end
    endtask

    task automatic add_txn(input string name, input logic [7:0] cmd, input logic [15:0] addr,
                           input int count, input int cut, input bit from_entry,
                           input logic [71:0] data);
        txn_t t;
        t.cmd            = cmd;
        t.addr           = addr;
        t.count          = 4'(count);
        t.cut_bits       = 3'(cut);
        t.exp_from_entry = from_entry;
        t.data           = data;
        txns.push_back(t);
        names.push_back(name);
    endtask

    task automatic build_table();
        logic [15:0] raddr [3];
        int          rcnt [3];
        logic [71:0] rdata [3];
        add_txn("single_write", CMD_WRITE, 16'h0010, 1, 0, 1'b0, 72'ha7);
        add_txn("single_read", CMD_READ, 16'h0010, 1, 0, 1'b0, 72'h0);
        add_txn("burst_write", CMD_WRITE, 16'h00fc, 8, 0, 1'b0, 72'h00_f8e7d6c5b4a39281);
        add_txn("burst_read", CMD_READ, 16'h00fc, 8, 0, 1'b0, 72'h0);
        add_txn("low_write", CMD_WRITE, 16'h0000, 8, 0, 1'b0, 72'h00_8877665544332211);
        add_txn("alias_0400", CMD_READ, 16'h0400, 1, 0, 1'b1, 72'h11);
        add_txn("alias_fc05", CMD_READ, 16'hfc05, 1, 0, 1'b1, 72'h66);
        add_txn("partial_write", CMD_WRITE, 16'h0120, 2, 5, 1'b0, 72'hff_c33c);
        add_txn("partial_read", CMD_READ, 16'h0120, 3, 0, 1'b0, 72'h0);
        add_txn("bad_cmd", 8'ha5, 16'h0010, 2, 0, 1'b0, 72'h5a5a);
        add_txn("bad_cmd_read", CMD_READ, 16'h0010, 1, 0, 1'b0, 72'h0);
        for (int k = 0; k < 3; k++) begin
            raddr[k] = 16'($urandom);
            rcnt[k]  = 1 + int'($urandom % 8);
            rdata[k] = {8'h00, $urandom, $urandom};
            add_txn($sformatf("rand_write_%0d", k), CMD_WRITE, raddr[k], rcnt[k], 0,
                    1'b0, rdata[k]);
        end
        for (int k = 0; k < 3; k++) begin
            add_txn($sformatf("rand_read_%0d", k), CMD_READ, raddr[k], rcnt[k], 0,
                    1'b0, 72'h0);
        end
    endtask

    task automatic run_txn(input int idx);
        txn_t        t;
        string       name;
        logic [7:0]  rx;
        logic [7:0]  exp;
        logic [15:0] a;
        bit          is_rd;
        bit          ignored;
        t       = txns[idx];
        name    = names[idx];
        is_rd   = (t.cmd == CMD_READ);
        ignored = (t.cmd != CMD_READ) && (t.cmd != CMD_WRITE);
        csn     = 1'b0;
        spi_byte(name, t.cmd, 8, ignored, rx);
        spi_byte(name, t.addr[15:8], 8, ignored, rx);
        spi_byte(name, t.addr[7:0], 8, ignored, rx);
        for (int i = 0; i < int'(t.count); i++) begin
            a = t.addr + 16'(i);                // wraps like the slave counter
            spi_byte(name, is_rd ? 8'h00 : t.data[8*i +: 8], 8, ignored, rx);
            if (is_rd) begin
                exp = t.exp_from_entry ? t.data[8*i +: 8] : model[a[ADDR_BITS-1:0]];
                check_byte(name, exp, rx);
            end else if (!ignored) begin
                model[a[ADDR_BITS-1:0]] = t.data[8*i +: 8];
            end
        end
        if (t.cut_bits != 0) begin
            // partial byte never reaches the model
            spi_byte(name, t.data[8*int'(t.count) +: 8], int'(t.cut_bits), ignored, rx);
        end
        csn = 1'b1;
        wait_cycles(HALF_CYCLES);               // slave sees csn high before next txn
        check_idle(name, ST_CMD);
    endtask

    initial begin
        rst_n       = 1'b0;
        csn         = 1'b1;
        sclk        = 1'b0;
        mosi        = 1'b0;
        table_ready = 1'b0;
        void'($urandom(32'hf0dd));
        foreach (model[i]) begin
            model[i] = 8'h00;                   // banks start zeroed
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(4);
        check_idle("after_reset", ST_CMD);
        foreach (txns[i]) begin
            run_txn(i);
        end
        $display("All tests passed!");
        $finish;
    end

    // watchdog at twice the nominal spi time of all transactions
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = 0;
        foreach (txns[i]) begin
            limit_ns += longint'(3 + int'(txns[i].count)) * 8 * 2 * HALF_CYCLES * CLK_NS * 2;
        end
        #(limit_ns);
        $display("Test failures found");
        $fatal(1, "simulation timed out after %0d ns", limit_ns);
    end

endmodule

`default_nettype wire

//--- verilog/bank_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bank_read_mux import mem_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire bank_rsp_t bank_rsp [BANK_COUNT],
    output mem_rsp_t       mem_rsp
);

    logic [BANK_COUNT-1:0] valid_vec;
    logic [7:0]            rdata_or;
    logic                  rdy_q;
    logic [7:0]            rdata_q;

    // idle banks contribute zero so a plain or picks the active one
    always_comb begin
        rdata_or = '0;
        for (int i = 0; i < BANK_COUNT; i++) begin
            valid_vec[i] = bank_rsp[i].valid;
            rdata_or     |= bank_rsp[i].rdata & {8{bank_rsp[i].valid}};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            rdy_q   <= |valid_vec;      // one cycle after valid
            rdata_q <= rdata_or;
        end
    end

    assign mem_rsp = '{rdy: rdy_q, rdata: rdata_q};

    // only the addressed bank answers a read
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(valid_vec))
        else $error("bank_read_mux: more than one bank valid");

endmodule

`default_nettype wire

//--- verilog/bank_select.sv
`timescale 1ns/1ps
`default_nettype none

module bank_select import mem_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire mem_req_t mem_req,
    output bank_req_t     bank_req [BANK_COUNT]
);

    logic                         rd_q;
    logic                         wr_q;
    logic [ROW_BITS+BANK_BITS-1:0] addr_q;
    logic [7:0]                   wdata_q;
    logic [BANK_BITS-1:0]         bank_sel;
    logic [BANK_COUNT-1:0]        bank_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= mem_req.rd;
            wr_q <= mem_req.wr;
        end
    end

    // upper address bits dropped, the space aliases every 1 KiB
    always_ff @(posedge clk) begin
        addr_q  <= mem_req.addr[ROW_BITS+BANK_BITS-1:0];
        wdata_q <= mem_req.wdata;
    end

    assign bank_sel = addr_q[ROW_BITS +: BANK_BITS];

    always_comb begin
        bank_en           = '0;
        bank_en[bank_sel] = 1'b1;   // one-hot
    end

    // row and data fan out to all banks, strobes only to the selected one
    always_comb begin
        for (int i = 0; i < BANK_COUNT; i++) begin
            bank_req[i].rd    = rd_q & bank_en[i];
            bank_req[i].wr    = wr_q & bank_en[i];
            bank_req[i].row   = addr_q[ROW_BITS-1:0];
            bank_req[i].wdata = wdata_q;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.rd && mem_req.wr))
        else $error("bank_select: rd and wr requested together");

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int BANK_COUNT = 4;
    localparam int BANK_BITS  = 2;  // address bits [9:8]
    localparam int ROW_BITS   = 8;  // address bits [7:0]

    // strobe from the spi slave, rd and wr are one-cycle pulses
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

    // per-bank request after address decode
    typedef struct packed {
        logic                rd;
        logic                wr;
        logic [ROW_BITS-1:0] row;
        logic [7:0]          wdata;
    } bank_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] rdata;
    } bank_rsp_t;

    // merged read return to the slave
    typedef struct packed {
        logic       rdy;
        logic [7:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // flops per pin in the input synchronizer
    localparam int SYNC_STAGES = 2;

    // first byte of every transaction
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h00,
        CMD_READ  = 8'h01
    } spi_cmd_t;

    // phase of the slave within one csn-low window
    typedef enum logic [2:0] {
        ST_CMD,         // waiting for command byte
        ST_ADDR_HI,     // address msb
        ST_ADDR_LO,     // address lsb
        ST_DATA,        // payload bytes, address auto-increments
        ST_IGNORE       // unknown command, wait for csn high
    } spi_state_t;

endpackage

`default_nettype wire

//--- verilog/spirw_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spirw_slave import spi_pkg::*, mem_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           csn,
    input  wire           sclk,
    input  wire           mosi,
    output logic          miso,
    output mem_req_t      mem_req,
    input  wire mem_rsp_t mem_rsp
);

    logic [SYNC_STAGES-1:0] csn_sync;
    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_prev;
    logic                   csn_s;
    logic                   sclk_s;
    logic                   mosi_s;
    logic                   sclk_rise;
    logic                   sclk_fall;

    spi_state_t             state;
    logic                   is_read;
    logic [2:0]             bit_cnt;
    logic [6:0]             rx_shift;
    logic [7:0]             rx_byte;
    logic                   byte_done;
    logic [15:0]            addr;

    logic [7:0]             tx_shift;
    logic                   miso_q;

    logic                   req_rd;
    logic                   req_wr;
    logic [15:0]            req_addr;
    logic [7:0]             req_wdata;

    // pin synchronizers, new sample enters at bit 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csn_sync  <= '1;        // deselected
            sclk_sync <= '0;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            csn_sync  <= {csn_sync[SYNC_STAGES-2:0], csn};
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
            sclk_prev <= sclk_s;
        end
    end

    assign csn_s  = csn_sync[SYNC_STAGES-1];
    assign sclk_s = sclk_sync[SYNC_STAGES-1];
    assign mosi_s = mosi_sync[SYNC_STAGES-1];

    assign sclk_rise = ~csn_s & sclk_s & ~sclk_prev;
    assign sclk_fall = ~csn_s & ~sclk_s & sclk_prev;

    assign rx_byte   = {rx_shift, mosi_s};              // msb first
    assign byte_done = sclk_rise && (bit_cnt == 3'd7);  // eighth bit taken now

    // phase control and strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_CMD;
            is_read <= 1'b0;
            bit_cnt <= '0;
            req_rd  <= 1'b0;
            req_wr  <= 1'b0;
        end else begin
            req_rd <= 1'b0;
            req_wr <= 1'b0;
            if (csn_s) begin
                state   <= ST_CMD;
                bit_cnt <= '0;                          // partial byte dropped
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (byte_done) begin
                    case (state)
                        ST_CMD: begin
                            case (spi_cmd_t'(rx_byte))
                                CMD_WRITE: begin
                                    is_read <= 1'b0;
                                    state   <= ST_ADDR_HI;
                                end
                                CMD_READ: begin
                                    is_read <= 1'b1;
                                    state   <= ST_ADDR_HI;
                                end
                                default: state <= ST_IGNORE;
                            endcase
                        end
                        ST_ADDR_HI: state <= ST_ADDR_LO;
                        ST_ADDR_LO: begin
                            state  <= ST_DATA;
                            req_rd <= is_read;          // fetch first read byte
                        end
                        ST_DATA: begin
                            req_rd <= is_read;          // prefetch next address
                            req_wr <= ~is_read;
                        end
                        default: state <= ST_IGNORE;
                    endcase
                end
            end
        end
    end

    // byte assembly and address counter
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= rx_byte[6:0];
        end
        if (byte_done) begin
            case (state)
                ST_ADDR_HI: addr[15:8] <= rx_byte;
                ST_ADDR_LO: begin
                    req_addr <= {addr[15:8], rx_byte};
                    // reads start one ahead since the first fetch is issued here
                    addr     <= {addr[15:8], rx_byte} + {15'd0, is_read};
                end
                ST_DATA: begin
                    req_addr  <= addr;
                    req_wdata <= rx_byte;
                    addr      <= addr + 16'd1;
                end
                default: ;
            endcase
        end
    end

    // read byte shifts out after each falling sclk edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
            miso_q   <= 1'b0;
        end else if (csn_s) begin
            tx_shift <= '0;
            miso_q   <= 1'b0;
        end else if (mem_rsp.rdy && sclk_fall) begin
            miso_q   <= mem_rsp.rdata[7];               // load and shift together
            tx_shift <= {mem_rsp.rdata[6:0], 1'b0};
        end else if (mem_rsp.rdy) begin
            tx_shift <= mem_rsp.rdata;
        end else if (sclk_fall) begin
            miso_q   <= tx_shift[7];
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign miso = miso_q & ~csn;    // low while deselected

    assign mem_req = '{rd: req_rd, wr: req_wr, addr: req_addr, wdata: req_wdata};

    // fixed read latency through dispatcher, bank and merger
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.rd |-> ##3 mem_rsp.rdy)
        else $error("spirw_slave: no rdy 3 cycles after rd");

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.rdy |-> $past(mem_req.rd, 3))
        else $error("spirw_slave: rdy without a matching rd");

endmodule

`default_nettype wire

//--- verilog/spirw_sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module spirw_sram_top import mem_pkg::*; (
    input  wire clk,
    input  wire rst_n,
    input  wire csn,
    input  wire sclk,
    input  wire mosi,
    output wire miso
);

    mem_req_t  mem_req;                 // slave to dispatcher
    mem_rsp_t  mem_rsp;                 // merger to slave
    bank_req_t bank_req [BANK_COUNT];
    bank_rsp_t bank_rsp [BANK_COUNT];

    spirw_slave
    spirw_slave_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .csn(csn),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    bank_select
    bank_select_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .mem_req(mem_req),
        .bank_req(bank_req)
    );

    // banks 0..3 cover address bits [9:8]
    for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
        sram_bank
        sram_bank_inst
        (
            .clk(clk),
            .rst_n(rst_n),
            .bank_req(bank_req[i]),
            .bank_rsp(bank_rsp[i])
        );
    end

    bank_read_mux
    bank_read_mux_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .bank_rsp(bank_rsp),
        .mem_rsp(mem_rsp)
    );

endmodule

`default_nettype wire

//--- verilog/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank import mem_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire bank_req_t bank_req,
    output bank_rsp_t      bank_rsp
);

    logic [7:0] mem [2**ROW_BITS] = '{default: 8'h00};
    logic [7:0] rdata_q;
    logic       valid_q;

    // single port, write and registered read
    always_ff @(posedge clk) begin
        if (bank_req.wr) begin
            mem[bank_req.row] <= bank_req.wdata;
        end
        if (bank_req.rd) begin
            rdata_q <= mem[bank_req.row];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bank_req.rd;     // one cycle after rd
        end
    end

    assign bank_rsp = '{valid: valid_q, rdata: rdata_q};

endmodule

`default_nettype wire
